//--- verilog/sw_cfg_pkg.sv
package sw_cfg_pkg;

    // sequence geometry
    localparam int REF_LEN_MAX  = 16;
    localparam int READ_LEN_MAX = 8;

    // wavefront spans ref_len + read_len - 1 cycles at most
    localparam int CYCLE_W = $clog2(REF_LEN_MAX + READ_LEN_MAX);

    // one nucleotide
    typedef logic [1:0] base_t;

    // first base sits in the top pair
    typedef logic [2*REF_LEN_MAX-1:0]  ref_seq_t;
    typedef logic [2*READ_LEN_MAX-1:0] read_seq_t;

    // 1-based lengths
    typedef logic [$clog2(REF_LEN_MAX):0]  ref_len_t;
    typedef logic [$clog2(READ_LEN_MAX):0] read_len_t;

    // 0-based positions
    typedef logic [$clog2(REF_LEN_MAX)-1:0]  col_t;
    typedef logic [$clog2(READ_LEN_MAX)-1:0] row_t;

    typedef logic [CYCLE_W-1:0] cycle_t;

endpackage

//--- verilog/sw_score_pkg.sv
package sw_score_pkg;

    localparam int SCORE_W = 10;

    typedef logic signed [SCORE_W-1:0] score_t;

    // linear substitution
    localparam score_t MATCH_SCORE    = score_t'(1);
    localparam score_t MISMATCH_SCORE = score_t'(-4);

    // affine gap: open on the first gap cell, extend after
    localparam score_t GAP_OPEN   = score_t'(-6);
    localparam score_t GAP_EXTEND = score_t'(-1);

endpackage

//--- verilog/sw_pe.sv
`timescale 1ns/1ps

module sw_pe
    import sw_cfg_pkg::*;
    import sw_score_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   i_clear,
    input  logic   i_row_en,
    input  base_t  i_read_base,
    input  base_t  i_ref_base,
    input  logic   i_ref_base_valid,
    input  score_t i_up_h,
    input  score_t i_up_f,
    input  score_t i_diag_h,
    output score_t o_h,
    output score_t o_f,
    output score_t o_h_prev,
    output base_t  o_ref_base,
    output logic   o_ref_base_valid,
    output logic   o_cell_valid
);

    score_t h_q;
    score_t h_prev_q;
    score_t e_q;
    score_t f_q;
    score_t subst;
    score_t e_d;
    score_t f_d;
    score_t h_d;
    base_t  base_q;
    logic   base_valid_q;
    logic   cell_valid_q;
    logic   en;

    // max of three, floored at zero
    function automatic score_t max3_clamp(score_t a, score_t b, score_t c);
        score_t m;
        m = (a > b) ? a : b;
        m = (c > m) ? c : m;
        return (m > 0) ? m : '0;
    endfunction

    assign en = i_ref_base_valid && i_row_en;

    always_comb begin
        subst = (i_read_base == i_ref_base) ? MATCH_SCORE : MISMATCH_SCORE;
        // gap along the row uses own previous cell
        e_d = max3_clamp('0, e_q + GAP_EXTEND, h_q + GAP_OPEN);
        // gap along the column comes from the row above
        f_d = max3_clamp('0, i_up_f + GAP_EXTEND, i_up_h + GAP_OPEN);
        h_d = max3_clamp(i_diag_h + subst, e_d, f_d);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_q          <= '0;
            h_prev_q     <= '0;
            e_q          <= '0;
            f_q          <= '0;
            cell_valid_q <= 1'b0;
            base_valid_q <= 1'b0;
        end else if (i_clear) begin
            h_q          <= '0;
            h_prev_q     <= '0;
            e_q          <= '0;
            f_q          <= '0;
            cell_valid_q <= 1'b0;
            base_valid_q <= 1'b0;
        end else begin
            cell_valid_q <= en;
            base_valid_q <= i_ref_base_valid;
            // hold between cells so the next row still sees them
            if (en) begin
                h_prev_q <= h_q;
                h_q      <= h_d;
                e_q      <= e_d;
                f_q      <= f_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        base_q <= i_ref_base;
    end

    assign o_h              = h_q;
    assign o_f              = f_q;
    assign o_h_prev         = h_prev_q;
    assign o_ref_base       = base_q;
    assign o_ref_base_valid = base_valid_q;
    assign o_cell_valid     = cell_valid_q;

endmodule

//--- verilog/sw_pe_array.sv
`timescale 1ns/1ps

module sw_pe_array
    import sw_cfg_pkg::*;
    import sw_score_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_clear,
    input  base_t                   i_ref_base,
    input  logic                    i_ref_base_valid,
    input  read_seq_t               i_read_seq,
    input  read_len_t               i_read_len,
    output score_t                  o_row_h [READ_LEN_MAX],
    output logic [READ_LEN_MAX-1:0] o_row_valid
);

    // entry r feeds row r, entry r+1 is driven by row r
    score_t                h_chain    [READ_LEN_MAX+1];
    score_t                f_chain    [READ_LEN_MAX+1];
    score_t                diag_chain [READ_LEN_MAX+1];
    base_t                 base_chain [READ_LEN_MAX+1];
    logic [READ_LEN_MAX:0] bv_chain;
    logic [READ_LEN_MAX-1:0] row_en;

    // top row sees an all-zero row above it
    assign h_chain[0]    = '0;
    assign f_chain[0]    = '0;
    assign diag_chain[0] = '0;
    assign base_chain[0] = i_ref_base;
    assign bv_chain[0]   = i_ref_base_valid;

    // rows past the read length stay idle
    always_comb begin
        for (int r = 0; r < READ_LEN_MAX; r++) begin
            row_en[r] = (r < int'(i_read_len));
        end
    end

    for (genvar r = 0; r < READ_LEN_MAX; r++) begin : g_row
        sw_pe pe_i (
            .clk              (clk),
            .rst              (rst),
            .i_clear          (i_clear),
            .i_row_en         (row_en[r]),
            .i_read_base      (i_read_seq[2*(READ_LEN_MAX-r)-1 -: 2]),
            .i_ref_base       (base_chain[r]),
            .i_ref_base_valid (bv_chain[r]),
            .i_up_h           (h_chain[r]),
            .i_up_f           (f_chain[r]),
            .i_diag_h         (diag_chain[r]),
            .o_h              (h_chain[r+1]),
            .o_f              (f_chain[r+1]),
            .o_h_prev         (diag_chain[r+1]),
            .o_ref_base       (base_chain[r+1]),
            .o_ref_base_valid (bv_chain[r+1]),
            .o_cell_valid     (o_row_valid[r])
        );

        assign o_row_h[r] = h_chain[r+1];
    end

endmodule

//--- verilog/sw_best_select.sv
`timescale 1ns/1ps

module sw_best_select
    import sw_cfg_pkg::*;
    import sw_score_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_clear,
    input  score_t                  i_row_h [READ_LEN_MAX],
    input  logic [READ_LEN_MAX-1:0] i_row_valid,
    input  logic                    i_scan_start,
    input  read_len_t               i_read_len,
    output logic                    o_scan_done,
    output score_t                  o_score,
    output row_t                    o_row,
    output col_t                    o_col
);

    score_t row_max [READ_LEN_MAX];
    col_t   row_col [READ_LEN_MAX];
    col_t   col_cnt [READ_LEN_MAX];
    score_t nxt_max [READ_LEN_MAX];
    col_t   nxt_col [READ_LEN_MAX];
    logic   scanning;
    row_t   scan_row;
    score_t best;
    row_t   best_row;
    col_t   best_col;

    // strictly greater keeps the earliest column
    always_comb begin
        for (int r = 0; r < READ_LEN_MAX; r++) begin
            if (i_row_valid[r] && (i_row_h[r] > row_max[r])) begin
                nxt_max[r] = i_row_h[r];
                nxt_col[r] = col_cnt[r];
            end else begin
                nxt_max[r] = row_max[r];
                nxt_col[r] = row_col[r];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < READ_LEN_MAX; r++) begin
                row_max[r] <= '0;
                row_col[r] <= '0;
                col_cnt[r] <= '0;
            end
        end else if (i_clear) begin
            for (int r = 0; r < READ_LEN_MAX; r++) begin
                row_max[r] <= '0;
                row_col[r] <= '0;
                col_cnt[r] <= '0;
            end
        end else begin
            for (int r = 0; r < READ_LEN_MAX; r++) begin
                row_max[r] <= nxt_max[r];
                row_col[r] <= nxt_col[r];
                if (i_row_valid[r]) begin
                    col_cnt[r] <= col_cnt[r] + col_t'(1);
                end
            end
        end
    end

    assign o_scan_done = scanning && (read_len_t'(scan_row) == i_read_len - read_len_t'(1));

    // one row per cycle; nxt_* also covers a last cell landing on scan cycle 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanning <= 1'b0;
            scan_row <= '0;
            best     <= '0;
            best_row <= '0;
            best_col <= '0;
        end else if (i_scan_start) begin
            scanning <= 1'b1;
            scan_row <= '0;
            best     <= '0;
            best_row <= '0;
            best_col <= '0;
        end else if (scanning) begin
            if (nxt_max[scan_row] > best) begin
                best     <= nxt_max[scan_row];
                best_row <= scan_row;
                best_col <= nxt_col[scan_row];
            end
            scan_row <= scan_row + row_t'(1);
            if (o_scan_done) begin
                scanning <= 1'b0;
            end
        end
    end

    assign o_score = best;
    assign o_row   = best_row;
    assign o_col   = best_col;

endmodule

//--- verilog/sw_ctrl.sv
`timescale 1ns/1ps

module sw_ctrl
    import sw_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_valid,
    input  ref_seq_t  i_ref_seq,
    input  read_seq_t i_read_seq,
    input  ref_len_t  i_ref_len,
    input  read_len_t i_read_len,
    input  logic      i_ready,
    input  logic      i_scan_done,
    output logic      o_ready,
    output logic      o_valid,
    output logic      o_clear,
    output base_t     o_ref_base,
    output logic      o_ref_base_valid,
    output read_seq_t o_read_seq,
    output read_len_t o_read_len,
    output logic      o_scan_start
);

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_compute,
        st_scan,
        st_done
    } state_t;

    state_t    state;
    state_t    state_n;
    ref_seq_t  ref_shift;
    read_seq_t read_seq;
    ref_len_t  ref_len;
    read_len_t read_len;
    cycle_t    cycle;
    cycle_t    last_cycle;
    logic      accept;
    logic      compute_end;

    // wavefront covers ref_len + read_len - 1 cycles, counted from 0
    assign accept      = (state == st_idle) && i_valid;
    assign last_cycle  = cycle_t'(ref_len) + cycle_t'(read_len) - cycle_t'(2);
    assign compute_end = (state == st_compute) && (cycle == last_cycle);

    always_comb begin
        state_n = state;
        case (state)
            st_idle:    if (i_valid) state_n = st_load;
            st_load:    state_n = st_compute;
            st_compute: if (compute_end) state_n = st_scan;
            st_scan:    if (i_scan_done) state_n = st_done;
            st_done:    if (i_ready) state_n = st_idle;
            default:    state_n = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            cycle    <= '0;
            ref_len  <= '0;
            read_len <= '0;
        end else begin
            state <= state_n;
            if (accept) begin
                ref_len  <= i_ref_len;
                read_len <= i_read_len;
            end
            // wavefront step count, cleared in load
            if (state == st_load) begin
                cycle <= '0;
            end else if (state == st_compute) begin
                cycle <= cycle + cycle_t'(1);
            end
        end
    end

    // reference leaves one base per compute cycle, first base first
    always_ff @(posedge clk) begin
        if (accept) begin
            ref_shift <= i_ref_seq;
            read_seq  <= i_read_seq;
        end else if (state == st_compute) begin
            ref_shift <= ref_shift << 2;
        end
    end

    assign o_ready          = (state == st_idle);
    assign o_valid          = (state == st_done);
    assign o_clear          = (state == st_load);
    assign o_ref_base       = ref_shift[2*REF_LEN_MAX-1 -: 2];
    assign o_ref_base_valid = (state == st_compute) && (cycle < cycle_t'(ref_len));
    assign o_read_seq       = read_seq;
    assign o_read_len       = read_len;
    assign o_scan_start     = compute_end;

endmodule

//--- verilog/sw_top.sv
`timescale 1ns/1ps

module sw_top
    import sw_cfg_pkg::*;
    import sw_score_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_valid,
    input  ref_seq_t  i_ref_seq,
    input  read_seq_t i_read_seq,
    input  ref_len_t  i_ref_len,
    input  read_len_t i_read_len,
    input  logic      i_ready,
    output logic      o_ready,
    output logic      o_valid,
    output score_t    o_score,
    output row_t      o_row,
    output col_t      o_col
);

    logic                    clear;
    base_t                   ref_base;
    logic                    ref_base_valid;
    read_seq_t               read_seq;
    read_len_t               read_len;
    logic                    scan_start;
    logic                    scan_done;
    score_t                  row_h [READ_LEN_MAX];
    logic [READ_LEN_MAX-1:0] row_valid;

    sw_ctrl ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .i_valid          (i_valid),
        .i_ref_seq        (i_ref_seq),
        .i_read_seq       (i_read_seq),
        .i_ref_len        (i_ref_len),
        .i_read_len       (i_read_len),
        .i_ready          (i_ready),
        .i_scan_done      (scan_done),
        .o_ready          (o_ready),
        .o_valid          (o_valid),
        .o_clear          (clear),
        .o_ref_base       (ref_base),
        .o_ref_base_valid (ref_base_valid),
        .o_read_seq       (read_seq),
        .o_read_len       (read_len),
        .o_scan_start     (scan_start)
    );

    sw_pe_array pe_array_i (
        .clk              (clk),
        .rst              (rst),
        .i_clear          (clear),
        .i_ref_base       (ref_base),
        .i_ref_base_valid (ref_base_valid),
        .i_read_seq       (read_seq),
        .i_read_len       (read_len),
        .o_row_h          (row_h),
        .o_row_valid      (row_valid)
    );

    sw_best_select best_select_i (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (clear),
        .i_row_h      (row_h),
        .i_row_valid  (row_valid),
        .i_scan_start (scan_start),
        .i_read_len   (read_len),
        .o_scan_done  (scan_done),
        .o_score      (o_score),
        .o_row        (o_row),
        .o_col        (o_col)
    );

endmodule

//--- sim/sw_tb_clk.sv
`timescale 1ns/1ps

module sw_tb_clk (
    output logic o_clk
);

    localparam time HALF_PERIOD = 4ns;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

//--- include/sw_tb_model.svh
`ifndef SW_TB_MODEL_SVH
`define SW_TB_MODEL_SVH

function automatic int max_of(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// full matrix fill, index 0 is the zero border
function automatic void model_align(
    input  ref_seq_t  ref_seq,
    input  read_seq_t read_seq,
    input  int        ref_len,
    input  int        read_len,
    output int        score,
    output int        row,
    output int        col
);
    int    h [READ_LEN_MAX+1][REF_LEN_MAX+1];
    int    e [READ_LEN_MAX+1][REF_LEN_MAX+1];
    int    f [READ_LEN_MAX+1][REF_LEN_MAX+1];
    int    s;
    base_t qb;
    base_t rb;
    score = 0;
    row   = 0;
    col   = 0;
    for (int i = 0; i <= READ_LEN_MAX; i++) begin
        for (int j = 0; j <= REF_LEN_MAX; j++) begin
            h[i][j] = 0;
            e[i][j] = 0;
            f[i][j] = 0;
        end
    end
    for (int i = 1; i <= read_len; i++) begin
        qb = read_seq[2*(READ_LEN_MAX-i+1)-1 -: 2];
        for (int j = 1; j <= ref_len; j++) begin
            rb = ref_seq[2*(REF_LEN_MAX-j+1)-1 -: 2];
            s = (qb == rb) ? int'(MATCH_SCORE) : int'(MISMATCH_SCORE);
            e[i][j] = max_of(0, max_of(e[i][j-1] + int'(GAP_EXTEND),
                                       h[i][j-1] + int'(GAP_OPEN)));
            f[i][j] = max_of(0, max_of(f[i-1][j] + int'(GAP_EXTEND),
                                       h[i-1][j] + int'(GAP_OPEN)));
            h[i][j] = max_of(max_of(0, h[i-1][j-1] + s), max_of(e[i][j], f[i][j]));
            // row-major walk, strictly greater keeps the earliest cell
            if (h[i][j] > score) begin
                score = h[i][j];
                row   = i - 1;
                col   = j - 1;
            end
        end
    end
endfunction

`endif

//--- sim/sw_tb.sv
`timescale 1ns/1ps

module sw_tb
    import sw_cfg_pkg::*;
    import sw_score_pkg::*;
;

    localparam int SEED         = 32'hff8b;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_JOBS     = 3 + NUM_RANDOM;
    localparam int MAX_HOLD     = 7;
    // load, wavefront, scan, handshake, stall and idle slack
    localparam int JOB_CYCLES   = 4 + REF_LEN_MAX + 2*READ_LEN_MAX + MAX_HOLD + 20;

    logic      clk;
    logic      rst;
    logic      i_valid;
    ref_seq_t  i_ref_seq;
    read_seq_t i_read_seq;
    ref_len_t  i_ref_len;
    read_len_t i_read_len;
    logic      i_ready;
    logic      o_ready;
    logic      o_valid;
    score_t    o_score;
    row_t      o_row;
    col_t      o_col;

    `include "sw_tb_model.svh"

    sw_tb_clk clk_gen_i (
        .o_clk (clk)
    );

    sw_top sw_top_i (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_ref_seq  (i_ref_seq),
        .i_read_seq (i_read_seq),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .i_ready    (i_ready),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_col      (o_col)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string field, input int exp,
                               input int act);
        assert (act == exp)
        else abort_run($sformatf("** Error %s: %s expected %0d, actual %0d",
                                 test, field, exp, act));
    endtask

    // result must hold while stalled
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_score) && $stable(o_row)
                                   && $stable(o_col))
    ) else abort_run("o_valid dropped or the result changed while i_ready was low");

    no_ready_in_done: assert property (
        @(posedge clk) disable iff (rst)
        o_valid |-> !o_ready
    ) else abort_run("o_ready was high while a result was waiting");

    release_on_ready: assert property (
        @(posedge clk) disable iff (rst)
        (o_valid && i_ready) |=> (!o_valid && o_ready)
    ) else abort_run("the engine did not return to idle after the result was taken");

    task automatic run_job(
        input string     name,
        input ref_seq_t  ref_seq,
        input read_seq_t read_seq,
        input int        ref_len,
        input int        read_len,
        input int        exp_score,
        input int        exp_row,
        input int        exp_col
    );
        int hold;
        int latency;
        hold    = int'($urandom_range(MAX_HOLD, 0));
        latency = 0;
        @(posedge clk);
        i_valid    <= 1'b1;
        i_ref_seq  <= ref_seq;
        i_read_seq <= read_seq;
        i_ref_len  <= ref_len_t'(ref_len);
        i_read_len <= read_len_t'(read_len);
        @(negedge clk);
        while (!o_ready) @(negedge clk);
        @(posedge clk);
        i_valid <= 1'b0;
        // edges from the accepting edge to the rise of o_valid
        @(negedge clk);
        while (!o_valid) begin
            latency++;
            @(negedge clk);
        end
        check_value(name, "latency", 1 + (ref_len + read_len - 1) + read_len, latency);
        check_value(name, "score", exp_score, int'(o_score));
        check_value(name, "row", exp_row, int'(o_row));
        check_value(name, "col", exp_col, int'(o_col));
        // stall while the properties watch the outputs
        repeat (hold) @(negedge clk);
        @(posedge clk);
        i_ready <= 1'b1;
        @(posedge clk);
        i_ready <= 1'b0;
    endtask

    initial begin
        repeat (RESET_CYCLES + NUM_JOBS * JOB_CYCLES) @(posedge clk);
        abort_run("timeout: the DUT did not finish all jobs in time");
    end

    initial begin
        ref_seq_t  rs;
        read_seq_t qs;
        int        rl;
        int        ql;
        int        mode;
        int        off;
        int        es;
        int        er;
        int        ec;
        void'($urandom(SEED));
        rst        = 1'b1;
        i_valid    = 1'b0;
        i_ref_seq  = '0;
        i_read_seq = '0;
        i_ref_len  = '0;
        i_read_len = '0;
        i_ready    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset", "o_ready", 1, int'(o_ready));
        check_value("reset", "o_valid", 0, int'(o_valid));

        // read sits at reference bases 4..11
        run_job("exact_copy", 32'hff1b_e4ff, 16'h1be4, 16, 8, 8, 7, 11);
        run_job("no_match", 32'h0000_0000, 16'h5555, 16, 8, 0, 0, 0);
        run_job("single_base", 32'h8000_0000, 16'h8000, 1, 1, 1, 0, 0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            mode = int'($urandom_range(2, 0));
            rs   = ref_seq_t'($urandom);
            qs   = read_seq_t'($urandom);
            if (mode == 0) begin
                rl = int'($urandom_range(REF_LEN_MAX, 1));
                ql = int'($urandom_range(READ_LEN_MAX, 1));
            end else begin
                // long runs push H past the gap open cost
                rl  = REF_LEN_MAX;
                ql  = (mode == 1) ? READ_LEN_MAX
                                  : int'($urandom_range(READ_LEN_MAX, READ_LEN_MAX - 1));
                off = int'($urandom_range(REF_LEN_MAX - ql, 0));
                for (int k = 0; k < ql; k++) begin
                    qs[2*(READ_LEN_MAX-k)-1 -: 2] = rs[2*(REF_LEN_MAX-off-k)-1 -: 2];
                end
                if (mode == 1) begin
                    qs[1:0] = base_t'($urandom);
                end
            end
            model_align(rs, qs, rl, ql, es, er, ec);
            run_job($sformatf("random_%0d", n), rs, qs, rl, ql, es, er, ec);
        end

        repeat (2) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- sw_top.f
+incdir+include
verilog/sw_cfg_pkg.sv
verilog/sw_score_pkg.sv
verilog/sw_pe.sv
verilog/sw_pe_array.sv
verilog/sw_best_select.sv
verilog/sw_ctrl.sv
verilog/sw_top.sv
sim/sw_tb_clk.sv
sim/sw_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sw_tb
FILELIST = sw_top.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
